/* Bender.yml */
package:
  name: wasm_cpu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/wasm_pkg.sv
      - src/code_memory.sv
      - src/leb128_decoder.sv
      - src/value_stack.sv
      - src/cpu_core.sv
      - src/wasm_cpu.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/wasm_cpu_assertions.sv
      - tests/tb_wasm_cpu.sv

/* flist.f */
+incdir+src
src/wasm_pkg.sv
src/code_memory.sv
src/leb128_decoder.sv
src/value_stack.sv
src/cpu_core.sv
src/wasm_cpu.sv
tests/wasm_cpu_assertions.sv
tests/tb_wasm_cpu.sv

/* src/code_memory.sv */
`timescale 1ns/1ps
`include "wasm_params.svh"

module code_memory (
  input  logic                       clk,
  input  logic                       load_en,
  input  logic [`CODE_ADDR_W-1:0]    load_addr,
  input  logic [7:0]                 load_byte,
  input  logic [`CODE_ADDR_W-1:0]    fetch_addr,
  output logic [`FETCH_BYTES*8-1:0]  fetch_window,
  output logic                       fetch_error
);

  localparam int MEM_SIZE = 2 ** `CODE_ADDR_W;

  logic [7:0] mem [MEM_SIZE];
  // One past the highest loaded address
  logic [`CODE_ADDR_W:0] code_limit;
  logic [`CODE_ADDR_W:0] byte_addr;
  logic [`FETCH_BYTES*8-1:0] window_next;

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_byte;
      // Writing address 0 starts a new program
      if (load_addr == '0) begin
        code_limit <= 'd1;
      end else if ({1'b0, load_addr} >= code_limit) begin
        code_limit <= {1'b0, load_addr} + 1'b1;
      end
    end
  end

  // Bytes at or past the loaded limit read as zero
  always_comb begin
    window_next = '0;
    byte_addr = '0;
    for (int i = 0; i < `FETCH_BYTES; i++) begin
      byte_addr = {1'b0, fetch_addr} + (`CODE_ADDR_W + 1)'(i);
      if (byte_addr < code_limit) begin
        window_next[8*i +: 8] = mem[byte_addr[`CODE_ADDR_W-1:0]];
      end
    end
  end

  always_ff @(posedge clk) begin
    fetch_window <= window_next;
    fetch_error  <= ({1'b0, fetch_addr} >= code_limit);
  end

endmodule

/* src/cpu_core.sv */
`timescale 1ns/1ps
`include "wasm_params.svh"

module cpu_core
  import wasm_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  output logic [`CODE_ADDR_W-1:0]   fetch_addr,
  input  logic [`FETCH_BYTES*8-1:0] fetch_window,
  input  logic                      fetch_error,
  input  logic [63:0]               imm_value,
  input  logic [3:0]                imm_len,
  output stack_op_e                 stack_op,
  output tagged_value_t             stack_data,
  input  tagged_value_t             stack_tos,
  input  stack_status_e             stack_status,
  output logic [63:0]               result,
  output value_type_e               result_type,
  output logic                      result_empty,
  output logic                      halted,
  output trap_e                     trap
);

  typedef enum logic [2:0] {
    st_fetch, st_fetch2, st_exec, st_exec2, st_exec3
  } state_e;

  state_e                  state;
  logic [`CODE_ADDR_W-1:0] pc;
  logic [7:0]              opcode;
  // Binary op and its popped top operand, held until EXEC3
  logic [7:0]              bin_op;
  tagged_value_t           top_operand;
  value_type_e             bin_type;
  logic [63:0]             bin_result;

  assign opcode = fetch_window[7:0];

  // Lower operand is the new top of stack after the pop
  always_comb begin
    bin_type   = val_i32;
    bin_result = '0;
    case (bin_op)
      op_i32_eq:  bin_result = {63'b0, stack_tos.payload[31:0] == top_operand.payload[31:0]};
      op_i32_add: bin_result = {32'b0, stack_tos.payload[31:0] + top_operand.payload[31:0]};
      op_i32_sub: bin_result = {32'b0, stack_tos.payload[31:0] - top_operand.payload[31:0]};
      op_i64_eq: begin
        bin_type   = val_i64;
        bin_result = {63'b0, stack_tos.payload == top_operand.payload};
      end
      op_i64_add: begin
        bin_type   = val_i64;
        bin_result = stack_tos.payload + top_operand.payload;
      end
      op_i64_sub: begin
        bin_type   = val_i64;
        bin_result = stack_tos.payload - top_operand.payload;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    stack_op <= stack_none;
    if (reset) begin
      state        <= st_fetch;
      pc           <= '0;
      halted       <= 1'b0;
      trap         <= trap_none;
      result       <= '0;
      result_type  <= val_i32;
      result_empty <= 1'b0;
    end else if (!halted && trap == trap_none) begin
      case (state)
        st_fetch: begin
          fetch_addr <= pc;
          pc         <= pc + 1'b1;
          state      <= st_fetch2;
        end
        // Window arrives while the previous stack op settles
        st_fetch2: begin
          if (stack_status inside {status_overflow, status_underflow}) trap <= trap_stack_error;
          else state <= st_exec;
        end
        st_exec: begin
          state <= st_fetch;
          if (fetch_error) begin
            trap <= trap_code_error;
          end else begin
            case (opcode)
              op_unreachable: trap <= trap_unreachable;
              op_nop: begin
              end
              op_end: begin
                result       <= stack_tos.payload;
                result_type  <= stack_tos.tag;
                result_empty <= (stack_status == status_empty);
                halted       <= 1'b1;
              end
              op_drop: begin
                if (stack_status == status_empty) trap <= trap_stack_error;
                else stack_op <= stack_pop;
              end
              op_i32_const: begin
                stack_op   <= stack_push;
                stack_data <= '{tag: val_i32, payload: {32'b0, imm_value[31:0]}};
                pc         <= pc + (`CODE_ADDR_W)'(imm_len);
              end
              op_i64_const: begin
                stack_op   <= stack_push;
                stack_data <= '{tag: val_i64, payload: imm_value};
                pc         <= pc + (`CODE_ADDR_W)'(imm_len);
              end
              op_i32_eqz: begin
                if (stack_status == status_empty) begin
                  trap <= trap_stack_error;
                end else if (stack_tos.tag != val_i32) begin
                  trap <= trap_type_mismatch;
                end else begin
                  stack_op   <= stack_replace;
                  stack_data <= '{tag: val_i32,
                                  payload: {63'b0, stack_tos.payload[31:0] == 32'b0}};
                end
              end
              op_i64_eqz: begin
                if (stack_status == status_empty) begin
                  trap <= trap_stack_error;
                end else if (stack_tos.tag != val_i64) begin
                  trap <= trap_type_mismatch;
                end else begin
                  stack_op   <= stack_replace;
                  stack_data <= '{tag: val_i64, payload: {63'b0, stack_tos.payload == 64'b0}};
                end
              end
              op_i32_eq, op_i64_eq, op_i32_add, op_i32_sub, op_i64_add, op_i64_sub: begin
                if (stack_status == status_empty) begin
                  trap <= trap_stack_error;
                end else begin
                  top_operand <= stack_tos;
                  bin_op      <= opcode;
                  stack_op    <= stack_pop;
                  state       <= st_exec2;
                end
              end
              default: trap <= trap_unknown_opcode;
            endcase
          end
        end
        st_exec2: state <= st_exec3;
        st_exec3: begin
          state <= st_fetch;
          // Only one operand was on the stack
          if (stack_status == status_empty) begin
            trap <= trap_stack_error;
          end else if (stack_tos.tag != bin_type || top_operand.tag != bin_type) begin
            trap <= trap_type_mismatch;
          end else begin
            stack_op   <= stack_replace;
            stack_data <= '{tag: bin_type, payload: bin_result};
          end
        end
        default: state <= st_fetch;
      endcase
    end
  end

endmodule

/* src/leb128_decoder.sv */
`timescale 1ns/1ps

module leb128_decoder (
  input  logic [79:0] window,
  output logic [63:0] value,
  output logic [3:0]  len
);

  localparam int MAX_BYTES = 10;

  logic [63:0] acc;
  logic [3:0]  count;
  logic        done;
  logic        sign;

  // Byte 0 sits in the low bits of the window
  always_comb begin
    acc   = '0;
    count = 4'(MAX_BYTES);
    done  = 1'b0;
    sign  = 1'b0;
    for (int i = 0; i < MAX_BYTES; i++) begin
      if (!done) begin
        acc  = acc | (64'(window[8*i +: 7]) << (7 * i));
        sign = window[8*i + 6];
        // Clear continuation bit ends the number
        if (!window[8*i + 7]) begin
          done  = 1'b1;
          count = 4'(i + 1);
        end
      end
    end
    // Sign-extend above the last group
    if (sign) begin
      acc = acc | ({64{1'b1}} << (7 * count));
    end
  end

  assign value = acc;
  assign len   = count;

endmodule

/* src/value_stack.sv */
`timescale 1ns/1ps
`include "wasm_params.svh"

module value_stack
  import wasm_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  stack_op_e     op,
  input  tagged_value_t data,
  output tagged_value_t tos,
  output stack_status_e status
);

  localparam int IDX_W = $clog2(`STACK_DEPTH);
  localparam int PTR_W = IDX_W + 1;

  tagged_value_t entries [`STACK_DEPTH];
  // Number of entries held
  logic [PTR_W-1:0] ptr;
  stack_status_e    fault;
  logic             full;
  logic             empty;
  logic [IDX_W-1:0] top_idx;
  logic             wr_en;
  logic [IDX_W-1:0] wr_idx;

  assign full    = (ptr == PTR_W'(`STACK_DEPTH));
  assign empty   = (ptr == '0);
  assign top_idx = IDX_W'(ptr - 1'b1);

  // Push writes above the top, replace overwrites it
  always_comb begin
    wr_en  = 1'b0;
    wr_idx = top_idx;
    if (fault == status_ok) begin
      if (op == stack_push && !full) begin
        wr_en  = 1'b1;
        wr_idx = IDX_W'(ptr);
      end else if (op == stack_replace && !empty) begin
        wr_en = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_idx] <= data;
    end
  end

  // Errors stick until reset and freeze the stack
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr   <= '0;
      fault <= status_ok;
    end else if (fault == status_ok) begin
      case (op)
        stack_push: begin
          if (full) fault <= status_overflow;
          else      ptr <= ptr + 1'b1;
        end
        stack_pop: begin
          if (empty) fault <= status_underflow;
          else       ptr <= ptr - 1'b1;
        end
        stack_replace: begin
          if (empty) fault <= status_underflow;
        end
        default: begin
        end
      endcase
    end
  end

  assign tos    = empty ? '0 : entries[top_idx];
  assign status = (fault != status_ok) ? fault : (empty ? status_empty : status_ok);

endmodule

/* src/wasm_cpu.sv */
`timescale 1ns/1ps
`include "wasm_params.svh"

module wasm_cpu
  import wasm_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    load_en,
  input  logic [`CODE_ADDR_W-1:0] load_addr,
  input  logic [7:0]              load_byte,
  output logic [63:0]             result,
  output value_type_e             result_type,
  output logic                    result_empty,
  output logic                    halted,
  output trap_e                   trap
);

  logic [`CODE_ADDR_W-1:0]   fetch_addr;
  logic [`FETCH_BYTES*8-1:0] fetch_window;
  logic                      fetch_error;
  logic [63:0]               imm_value;
  logic [3:0]                imm_len;
  stack_op_e                 stack_op;
  tagged_value_t             stack_data;
  tagged_value_t             stack_tos;
  stack_status_e             stack_status;

  code_memory u_code_memory (
    .clk          (clk),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_byte    (load_byte),
    .fetch_addr   (fetch_addr),
    .fetch_window (fetch_window),
    .fetch_error  (fetch_error)
  );

  // Immediate follows the opcode byte
  leb128_decoder u_leb128_decoder (
    .window (fetch_window[`FETCH_BYTES*8-1:8]),
    .value  (imm_value),
    .len    (imm_len)
  );

  value_stack u_value_stack (
    .clk    (clk),
    .reset  (reset),
    .op     (stack_op),
    .data   (stack_data),
    .tos    (stack_tos),
    .status (stack_status)
  );

  cpu_core u_cpu_core (
    .clk          (clk),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fetch_window (fetch_window),
    .fetch_error  (fetch_error),
    .imm_value    (imm_value),
    .imm_len      (imm_len),
    .stack_op     (stack_op),
    .stack_data   (stack_data),
    .stack_tos    (stack_tos),
    .stack_status (stack_status),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .halted       (halted),
    .trap         (trap)
  );

endmodule

/* src/wasm_params.svh */
`ifndef WASM_PARAMS_SVH
`define WASM_PARAMS_SVH

// 64 bytes of code
`define CODE_ADDR_W 6
// Opcode plus up to 10 immediate bytes
`define FETCH_BYTES 11
`define STACK_DEPTH 8

`endif

/* src/wasm_pkg.sv */
package wasm_pkg;

  // Only i32 and i64 tags are produced
  typedef enum logic [1:0] {
    val_i32 = 2'd0,
    val_i64 = 2'd1,
    val_f32 = 2'd2,
    val_f64 = 2'd3
  } value_type_e;

  // i32 payloads are zero-extended into the low word
  typedef struct packed {
    value_type_e tag;
    logic [63:0] payload;
  } tagged_value_t;

  typedef enum logic [1:0] {
    stack_none    = 2'd0,
    stack_push    = 2'd1,
    stack_pop     = 2'd2,
    stack_replace = 2'd3
  } stack_op_e;

  // Overflow and underflow sort above empty
  typedef enum logic [1:0] {
    status_ok        = 2'd0,
    status_empty     = 2'd1,
    status_overflow  = 2'd2,
    status_underflow = 2'd3
  } stack_status_e;

  typedef enum logic [2:0] {
    trap_none           = 3'd0,
    trap_stack_error    = 3'd1,
    trap_code_error     = 3'd2,
    trap_unreachable    = 3'd3,
    trap_type_mismatch  = 3'd4,
    trap_unknown_opcode = 3'd5
  } trap_e;

  // Opcodes
  localparam logic [7:0] op_unreachable = 8'h00;
  localparam logic [7:0] op_nop         = 8'h01;
  localparam logic [7:0] op_end         = 8'h0B;
  localparam logic [7:0] op_drop        = 8'h1A;
  localparam logic [7:0] op_i32_const   = 8'h41;
  localparam logic [7:0] op_i64_const   = 8'h42;
  localparam logic [7:0] op_i32_eqz     = 8'h45;
  localparam logic [7:0] op_i32_eq      = 8'h46;
  localparam logic [7:0] op_i64_eqz     = 8'h50;
  localparam logic [7:0] op_i64_eq      = 8'h51;
  localparam logic [7:0] op_i32_add     = 8'h6A;
  localparam logic [7:0] op_i32_sub     = 8'h6B;
  localparam logic [7:0] op_i64_add     = 8'h7C;
  localparam logic [7:0] op_i64_sub     = 8'h7D;

endpackage

/* tests/tb_wasm_cpu.sv */
`timescale 1ns/1ps
`include "wasm_params.svh"

module tb_wasm_cpu
  import wasm_pkg::*;
();

  localparam int MAX_TESTS   = 24;
  localparam int RUN_TIMEOUT = 200;

  logic                    clk;
  logic                    reset;
  logic                    load_en;
  logic [`CODE_ADDR_W-1:0] load_addr;
  logic [7:0]              load_byte;
  logic [63:0]             result;
  value_type_e             result_type;
  logic                    result_empty;
  logic                    halted;
  trap_e                   trap;

  // Right-aligned program bytes with the first byte leftmost
  string        test_name  [MAX_TESTS];
  logic [127:0] prog_bytes [MAX_TESTS];
  int           prog_len   [MAX_TESTS];
  logic [63:0]  exp_result [MAX_TESTS];
  value_type_e  exp_type   [MAX_TESTS];
  logic         exp_empty  [MAX_TESTS];
  trap_e        exp_trap   [MAX_TESTS];
  int           num_tests;

  wasm_cpu u_dut (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_byte    (load_byte),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .halted       (halted),
    .trap         (trap)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_test(input string name, input logic [127:0] code, input int len,
                          input logic [63:0] res, input value_type_e typ,
                          input logic empty, input trap_e trp);
    test_name[num_tests]  = name;
    prog_bytes[num_tests] = code;
    prog_len[num_tests]   = len;
    exp_result[num_tests] = res;
    exp_type[num_tests]   = typ;
    exp_empty[num_tests]  = empty;
    exp_trap[num_tests]   = trp;
    num_tests++;
  endtask

  // Expected values worked out by hand from the LEB128 and wrap rules
  task automatic build_table();
    num_tests = 0;
    add_test("i32_const_small", 128'h41_05_0B, 3, 64'h5, val_i32, 1'b0, trap_none);
    add_test("i32_const_neg", 128'h41_7F_0B, 3, 64'h0000_0000_FFFF_FFFF, val_i32, 1'b0,
             trap_none);
    add_test("i32_const_multi", 128'h41_E5_8E_26_0B, 5, 64'h9_8765, val_i32, 1'b0, trap_none);
    add_test("i64_const_neg", 128'h42_C0_BB_78_0B, 5, 64'hFFFF_FFFF_FFFE_1DC0, val_i64, 1'b0,
             trap_none);
    // Ten immediate bytes, most negative i64
    add_test("i64_const_min", 128'h42_8080_8080_8080_8080_80_7F_0B, 12,
             64'h8000_0000_0000_0000, val_i64, 1'b0, trap_none);
    add_test("i32_add_wrap", 128'h41_7F_41_02_6A_0B, 6, 64'h1, val_i32, 1'b0, trap_none);
    add_test("i32_sub", 128'h41_03_41_05_6B_0B, 6, 64'h0000_0000_FFFF_FFFE, val_i32, 1'b0,
             trap_none);
    add_test("i64_add_wrap", 128'h42_7F_42_02_7C_0B, 6, 64'h1, val_i64, 1'b0, trap_none);
    add_test("i64_sub_neg", 128'h42_03_42_0A_7D_0B, 6, 64'hFFFF_FFFF_FFFF_FFF9, val_i64, 1'b0,
             trap_none);
    add_test("i32_eqz_true", 128'h41_00_45_0B, 4, 64'h1, val_i32, 1'b0, trap_none);
    add_test("i64_eqz_false", 128'h42_05_50_0B, 4, 64'h0, val_i64, 1'b0, trap_none);
    add_test("i32_eq_true", 128'h41_07_41_07_46_0B, 6, 64'h1, val_i32, 1'b0, trap_none);
    add_test("i64_eq_false", 128'h42_07_42_08_51_0B, 6, 64'h0, val_i64, 1'b0, trap_none);
    add_test("nop_drop", 128'h41_09_01_41_04_1A_0B, 7, 64'h9, val_i32, 1'b0, trap_none);
    add_test("end_empty", 128'h0B, 1, 64'h0, val_i32, 1'b1, trap_none);
    // Trapping programs leave the result outputs at their reset values
    add_test("unreachable", 128'h00, 1, 64'h0, val_i32, 1'b0, trap_unreachable);
    add_test("unknown_opcode", 128'h41_01_FC, 3, 64'h0, val_i32, 1'b0, trap_unknown_opcode);
    add_test("type_mismatch", 128'h41_01_41_02_7C_0B, 6, 64'h0, val_i32, 1'b0,
             trap_type_mismatch);
    add_test("drop_empty", 128'h1A_0B, 2, 64'h0, val_i32, 1'b0, trap_stack_error);
    add_test("run_past_end", 128'h41_01, 2, 64'h0, val_i32, 1'b0, trap_code_error);
    // The run before left an entry on the stack
    add_test("after_traps", 128'h42_2A_1A_0B, 4, 64'h0, val_i32, 1'b1, trap_none);
  endtask

  function automatic logic [7:0] program_byte(input int idx, input int pos);
    return prog_bytes[idx][8*(prog_len[idx]-1-pos) +: 8];
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_field(input string name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("ERR %s %s: expected %h, actual %h",
                                  name, field, expected, actual));
    end
  endtask

  // One byte per cycle while reset is high, for at least 4 reset cycles
  task automatic load_program(input int idx);
    int i;
    @(posedge clk);
    reset <= 1'b1;
    for (i = 0; i < prog_len[idx]; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= (`CODE_ADDR_W)'(i);
      load_byte <= program_byte(idx, i);
    end
    @(posedge clk);
    load_en <= 1'b0;
    for (i = prog_len[idx] + 1; i < 4; i++) begin
      @(posedge clk);
    end
    reset <= 1'b0;
  endtask

  task automatic wait_for_stop(input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk);
    check_field(test_name[idx], "halted after reset", 64'h0, 64'(halted));
    check_field(test_name[idx], "trap after reset", 64'(trap_none), 64'(trap));
    while (!halted && trap == trap_none && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted && trap == trap_none) begin
      stop_with_failure($sformatf("Test %s neither halted nor trapped within %0d cycles",
                                  test_name[idx], RUN_TIMEOUT));
    end
  endtask

  task automatic check_outputs(input int idx);
    // Status outputs must hold after the stop
    repeat (3) @(negedge clk);
    check_field(test_name[idx], "result", exp_result[idx], result);
    check_field(test_name[idx], "result_type", 64'(exp_type[idx]), 64'(result_type));
    check_field(test_name[idx], "result_empty", 64'(exp_empty[idx]), 64'(result_empty));
    check_field(test_name[idx], "halted", 64'(exp_trap[idx] == trap_none), 64'(halted));
    check_field(test_name[idx], "trap", 64'(exp_trap[idx]), 64'(trap));
  endtask

  always @(negedge clk) begin
    if (u_dut.u_assertions.fail_count != 0) begin
      stop_with_failure("A bound assertion on the DUT failed");
    end
  end

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_byte = '0;
    build_table();
    for (int t = 0; t < num_tests; t++) begin
      load_program(t);
      wait_for_stop(t);
      check_outputs(t);
    end
    if (u_dut.u_assertions.fail_count != 0) begin
      stop_with_failure("A bound assertion on the DUT failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

/* tests/wasm_cpu_assertions.sv */
`timescale 1ns/1ps

module wasm_cpu_assertions
  import wasm_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  halted,
  input trap_e trap
);

  // Number of failed assertions
  int fail_count = 0;

  // A trap code holds until reset
  trap_stable: assert property (@(posedge clk) disable iff (reset)
    (trap != trap_none) |=> $stable(trap))
    else begin
      fail_count++;
      $error("trap code changed without a reset");
    end

  halt_trap_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(halted && trap != trap_none))
    else begin
      fail_count++;
      $error("halted and trap active together");
    end

  // Once halted the core stays halted
  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else begin
      fail_count++;
      $error("halted dropped without a reset");
    end

endmodule

bind wasm_cpu wasm_cpu_assertions u_assertions (
  .clk    (clk),
  .reset  (reset),
  .halted (halted),
  .trap   (trap)
);
